// File: src/xc_pkg.sv
// correlator sizes, uart timing, frame constants and state enums.
`default_nettype none

package xc_pkg;

	// line and pair geometry.
	localparam int NUM_LINES   = 4;
	localparam int NUM_PAIRS   = NUM_LINES * (NUM_LINES - 1) / 2; // unordered pairs, 6.
	localparam int FRAME_WORDS = NUM_LINES + NUM_PAIRS;           // autos first, then crosses.

	// counter and word sizes.
	localparam int COUNT_W    = 16;
	localparam int WORD_IDX_W = 4; // holds 0..FRAME_WORDS.

	// integration window.
	localparam int INTEG_CYCLES = 256;
	localparam int WIN_W        = $clog2(INTEG_CYCLES);

	// uart bit timing, short so that simulation stays quick.
	localparam int CLKS_PER_BIT = 16;
	localparam int HALF_BIT     = CLKS_PER_BIT / 2;
	localparam int BAUD_W       = $clog2(CLKS_PER_BIT);

	// frame layout on tx.
	localparam logic [7:0] SYNC_BYTE = 8'hA5; // leads every frame.
	localparam int Q_IDX_W = 2;               // byte queue index, up to three bytes per word.

	// receiver states.
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// accumulator states.
	typedef enum logic [1:0] {
		acc_idle,
		acc_integrate,
		acc_unload
	} acc_state_t;

	// transmitter states.
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

endpackage

`default_nettype wire

// File: src/count_if.sv
// count word link from the accumulator to the frame serializer.
`timescale 1ns/1ps
`default_nettype none

interface count_if import xc_pkg::*; ();

	logic [COUNT_W-1:0] word; // counter value being handed over.
	logic word_valid;         // one-cycle strobe, only while busy is low.
	logic first;              // word 0, sync byte goes ahead of it.
	logic last;               // final word of the frame.
	logic busy;               // serializer still owns the previous word.

	// accumulator side.
	modport acc (
		output word, word_valid, first, last,
		input  busy
	);

	// serializer side.
	modport ser (
		input  word, word_valid, first, last,
		output busy
	);

endinterface

`default_nettype wire

// File: src/uart_rx.sv
// uart command receiver with start strobe on every complete byte.
`timescale 1ns/1ps
`default_nettype none

module uart_rx import xc_pkg::*; (
	input  logic clki,
	input  logic rst_n,
	input  logic rx,
	output logic start
);

	logic rx_m, rx_s;          // two-flop synchronizer.
	rx_state_t state;
	logic [BAUD_W-1:0] baud;   // cycles inside the current bit.
	logic [2:0] bit_cnt;       // data bit number.

	always_ff @(posedge clki or negedge rst_n) begin
		if (!rst_n) begin
			rx_m <= 1'b1; // line idles high.
			rx_s <= 1'b1;
		end else begin
			rx_m <= rx;
			rx_s <= rx_m;
		end
	end

	always_ff @(posedge clki or negedge rst_n) begin
		if (!rst_n) begin
			state   <= rx_idle;
			baud    <= '0;
			bit_cnt <= '0;
			start   <= 1'b0;
		end else begin
			start <= 1'b0; // strobe by default low.
			baud  <= baud + 1'b1;
			case (state)
				rx_idle: begin
					baud <= '0;
					if (!rx_s)
						state <= rx_start; // falling edge of start bit.
				end
				rx_start: if (baud == BAUD_W'(HALF_BIT - 1)) begin
					baud    <= '0;
					bit_cnt <= '0;
					state   <= rx_s ? rx_idle : rx_data; // glitch check at mid bit.
				end
				rx_data: if (baud == BAUD_W'(CLKS_PER_BIT - 1)) begin
					baud    <= '0; // now at middle of a data bit, value is not kept.
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= rx_stop;
				end
				rx_stop: if (baud == BAUD_W'(CLKS_PER_BIT - 1)) begin
					start <= rx_s; // good stop bit means a command.
					state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/line_sampler.sv
// pulse line synchronizer and rising edge detector.
`timescale 1ns/1ps
`default_nettype none

module line_sampler import xc_pkg::*; (
	input  logic clki,
	input  logic rst_n,
	input  logic [NUM_LINES-1:0] line_in,
	output logic [NUM_LINES-1:0] edges
);

	logic [NUM_LINES-1:0] meta;  // first sync stage.
	logic [NUM_LINES-1:0] sync;  // second sync stage.
	logic [NUM_LINES-1:0] prev;  // sync delayed by one cycle.

	// pin to edges takes three clocks: meta, sync, edges.
	always_ff @(posedge clki or negedge rst_n) begin
		if (!rst_n) begin
			meta  <= '0;
			sync  <= '0;
			prev  <= '0;
			edges <= '0;
		end else begin
			meta  <= line_in;
			sync  <= meta;
			prev  <= sync;
			edges <= sync & ~prev; // one pulse per rising edge.
		end
	end

endmodule

`default_nettype wire

// File: src/xc_accumulator.sv
// integration window, auto and cross counters at lag zero, word unload.
`timescale 1ns/1ps
`default_nettype none

module xc_accumulator import xc_pkg::*; (
	input  logic clki,
	input  logic rst_n,
	input  logic start,
	input  logic [NUM_LINES-1:0] edges,
	count_if.acc cnt
);

	acc_state_t state;
	logic [WIN_W-1:0] win_cnt;            // cycles spent inside the window.
	logic [WORD_IDX_W-1:0] widx;          // next word to hand out.
	logic [COUNT_W-1:0] line_cnt [NUM_LINES]; // autocorrelation at lag zero.
	logic [COUNT_W-1:0] pair_cnt [NUM_PAIRS]; // crosscorrelation at lag zero.
	logic [NUM_PAIRS-1:0] pair_hit;       // both lines of a pair rose this cycle.
	logic [COUNT_W-1:0] words [FRAME_WORDS];  // frame order view of the counters.

	// pair k of (a,b) with a < b, ordered (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	for (genvar a = 0; a < NUM_LINES; a++) begin : g_a
		for (genvar b = a + 1; b < NUM_LINES; b++) begin : g_b
			localparam int K = a * (2 * NUM_LINES - a - 1) / 2 + (b - a - 1);
			assign pair_hit[K] = edges[a] & edges[b];
		end
	end

	// lines first, then pairs.
	always_comb begin
		for (int i = 0; i < NUM_LINES; i++)
			words[i] = line_cnt[i];
		for (int k = 0; k < NUM_PAIRS; k++)
			words[NUM_LINES + k] = pair_cnt[k];
	end

	always_ff @(posedge clki or negedge rst_n) begin
		if (!rst_n) begin
			state          <= acc_idle;
			win_cnt        <= '0;
			widx           <= '0;
			cnt.word_valid <= 1'b0;
			cnt.first      <= 1'b0;
			cnt.last       <= 1'b0;
			for (int i = 0; i < NUM_LINES; i++)
				line_cnt[i] <= '0;
			for (int k = 0; k < NUM_PAIRS; k++)
				pair_cnt[k] <= '0;
		end else begin
			cnt.word_valid <= 1'b0; // single-cycle strobe.
			case (state)
				acc_idle: begin
					win_cnt <= '0;
					widx    <= '0;
					if (start)
						state <= acc_integrate; // window opens next cycle.
				end
				acc_integrate: begin
					for (int i = 0; i < NUM_LINES; i++)
						line_cnt[i] <= line_cnt[i] + COUNT_W'(edges[i]);
					for (int k = 0; k < NUM_PAIRS; k++)
						pair_cnt[k] <= pair_cnt[k] + COUNT_W'(pair_hit[k]);
					win_cnt <= win_cnt + 1'b1;
					if (win_cnt == WIN_W'(INTEG_CYCLES - 1))
						state <= acc_unload; // exactly INTEG_CYCLES counted.
				end
				acc_unload: begin
					// busy rises the cycle after word_valid, so skip a cycle after each word.
					if (!cnt.word_valid && !cnt.busy) begin
						if (widx == WORD_IDX_W'(FRAME_WORDS)) begin
							state <= acc_idle; // serializer took the last word.
							for (int i = 0; i < NUM_LINES; i++)
								line_cnt[i] <= '0;
							for (int k = 0; k < NUM_PAIRS; k++)
								pair_cnt[k] <= '0;
						end else begin
							cnt.word_valid <= 1'b1;
							cnt.first      <= (widx == '0);
							cnt.last       <= (widx == WORD_IDX_W'(FRAME_WORDS - 1));
							widx           <= widx + 1'b1;
						end
					end
				end
				default: state <= acc_idle;
			endcase
		end
	end

	// word payload, follows the index without reset.
	always_ff @(posedge clki) begin
		if (state == acc_unload && !cnt.word_valid && !cnt.busy &&
				widx != WORD_IDX_W'(FRAME_WORDS))
			cnt.word <= words[widx];
	end

endmodule

`default_nettype wire

// File: src/frame_serializer.sv
// frame serializer with word to byte queue and 8n1 uart transmitter.
`timescale 1ns/1ps
`default_nettype none

module frame_serializer import xc_pkg::*; (
	input  logic clki,
	input  logic rst_n,
	count_if.ser cnt,
	output logic tx
);

	tx_state_t state;
	logic [7:0] qbuf [3];          // sync, high, low, or high, low.
	logic [Q_IDX_W-1:0] qlen;      // bytes held for the current word.
	logic [Q_IDX_W-1:0] qidx;      // next byte to send.
	logic [7:0] shreg;             // byte being shifted out lsb first.
	logic [BAUD_W-1:0] baud;       // cycles inside the current bit.
	logic [2:0] bit_cnt;
	logic last_word;               // current word closes the frame.
	logic q_empty;
	logic bit_end;

	assign q_empty = (qidx == qlen);
	assign bit_end = (baud == BAUD_W'(CLKS_PER_BIT - 1));

	// byte queue payload.
	always_ff @(posedge clki) begin
		if (cnt.word_valid) begin
			qbuf[0] <= cnt.first ? SYNC_BYTE : cnt.word[15:8];
			qbuf[1] <= cnt.first ? cnt.word[15:8] : cnt.word[7:0];
			qbuf[2] <= cnt.word[7:0]; // only read after a sync byte.
		end
	end

	always_ff @(posedge clki or negedge rst_n) begin
		if (!rst_n) begin
			state     <= tx_idle;
			qlen      <= '0;
			qidx      <= '0;
			shreg     <= '0;
			baud      <= '0;
			bit_cnt   <= '0;
			last_word <= 1'b0;
			cnt.busy  <= 1'b0;
			tx        <= 1'b1; // idle mark.
		end else begin
			baud <= baud + 1'b1;
			if (cnt.word_valid) begin
				qlen      <= cnt.first ? Q_IDX_W'(3) : Q_IDX_W'(2);
				qidx      <= '0;
				last_word <= cnt.last;
				cnt.busy  <= 1'b1; // held until the word's last byte is out.
			end
			case (state)
				tx_idle: begin
					baud <= '0;
					if (!q_empty) begin
						shreg <= qbuf[qidx];
						qidx  <= qidx + 1'b1;
						tx    <= 1'b0; // start bit.
						state <= tx_start;
					end
				end
				tx_start: if (bit_end) begin
					baud    <= '0;
					bit_cnt <= '0;
					tx      <= shreg[0];
					shreg   <= shreg >> 1;
					state   <= tx_data;
				end
				tx_data: if (bit_end) begin
					baud <= '0;
					if (bit_cnt == 3'd7) begin
						tx    <= 1'b1; // stop bit.
						state <= tx_stop;
						// mid-frame words free the link here so the next word lands in time.
						if (q_empty && !last_word)
							cnt.busy <= 1'b0;
					end else begin
						tx      <= shreg[0];
						shreg   <= shreg >> 1;
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				tx_stop: if (bit_end) begin
					baud <= '0;
					if (!q_empty) begin
						shreg <= qbuf[qidx]; // next byte follows with no idle gap.
						qidx  <= qidx + 1'b1;
						tx    <= 1'b0;
						state <= tx_start;
					end else begin
						state <= tx_idle;
						if (last_word)
							cnt.busy <= 1'b0; // frame fully out so the accumulator can rearm.
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/correlator.sv
// correlator top level, receiver, sampler, accumulator and serializer.
`timescale 1ns/1ps
`default_nettype none

module correlator import xc_pkg::*; (
	input  logic clki,
	input  logic rst_n,
	input  logic rx,
	input  logic [NUM_LINES-1:0] line_in,
	output logic tx
);

	logic start;                  // command strobe from the receiver.
	logic [NUM_LINES-1:0] edges;  // rising edge pulses per line.

	count_if cnt_bus (); // accumulator to serializer words.

	uart_rx u_rx (
		.clki  (clki),
		.rst_n (rst_n),
		.rx    (rx),
		.start (start)
	);

	line_sampler u_sampler (
		.clki    (clki),
		.rst_n   (rst_n),
		.line_in (line_in),
		.edges   (edges)
	);

	xc_accumulator u_acc (
		.clki  (clki),
		.rst_n (rst_n),
		.start (start),
		.edges (edges),
		.cnt   (cnt_bus.acc)
	);

	frame_serializer u_ser (
		.clki  (clki),
		.rst_n (rst_n),
		.cnt   (cnt_bus.ser),
		.tx    (tx)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// testbench clock source and power-on reset.
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clki,
	output logic rst_n
);

	initial clki = 1'b0;
	always #5 clki = ~clki; // 10 ns period.

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clki);
		#1 rst_n = 1'b1; // released just after an edge, like every other input.
	end

endmodule

`default_nettype wire

// File: tests/tb_correlator.sv
// correlator testbench: command sender, tx monitor, line stimulus, model and assertions.
`timescale 1ns/1ps
`default_nettype none

module tb_correlator import xc_pkg::*; ();

	localparam int FRAME_BYTES = 1 + 2 * FRAME_WORDS; // sync byte, then two per word.
	localparam int TIMEOUT_CYCLES = 3 * (INTEG_CYCLES + FRAME_BYTES * 10 * CLKS_PER_BIT) + 2000;
	localparam int STIM_CYCLES = 180; // edges from 20 to 200 cycles after the stop bit.

	logic clki, rst_n, rx, tx;
	logic [NUM_LINES-1:0] line_in;
	logic [31:0] seed = 32'd90;
	int exp_cnt [FRAME_WORDS];         // model counts of the frame in flight.
	int errors = 0;
	int cycles = 0;
	int byte_cnt = 0;                  // bytes decoded on tx so far.
	int mon_pos = 0;                   // position of the last byte inside its frame.
	logic mon_valid = 1'b0;
	logic mon_stop = 1'b1;
	logic frame_gap = 1'b0;            // tx idle for one byte time.
	logic quiet = 1'b0;                // no traffic allowed on tx.
	logic [7:0] mon_byte = '0;
	logic [7:0] exp_byte = '0;

	tb_clock u_clock (.clki(clki), .rst_n(rst_n));

	correlator DUT (.clki(clki), .rst_n(rst_n), .rx(rx), .line_in(line_in), .tx(tx));

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// byte at a frame position, sync first then each word high byte first.
	function automatic logic [7:0] frame_byte(input int pos);
		logic [15:0] w;
		if (pos == 0)
			return SYNC_BYTE;
		w = 16'(exp_cnt[(pos - 1) / 2]);
		return (pos % 2 == 1) ? w[15:8] : w[7:0];
	endfunction

	task automatic send_cmd(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // start, data lsb first, stop.
		for (int i = 0; i < 10; i++) begin
			@(posedge clki);
			#1 rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge clki);
		end
	endtask

	// random pulses, every level held two cycles or more, some rises forced together.
	task automatic drive_pattern();
		logic [NUM_LINES-1:0] cur, nxt, rise;
		int held [NUM_LINES];
		int k;
		cur = '0;
		for (int i = 0; i < NUM_LINES; i++)
			held[i] = 2;
		repeat (20) @(posedge clki);
		for (int c = 0; c < STIM_CYCLES; c++) begin
			nxt = cur;
			for (int i = 0; i < NUM_LINES; i++) begin
				seed = lcg_next(seed);
				if (held[i] >= 2 && (seed[31:30] == 2'b00 || (c % 29 == 0 && !cur[i])))
					nxt[i] = !cur[i];
			end
			rise = nxt & ~cur;
			k = 0;
			for (int a = 0; a < NUM_LINES; a++) begin
				exp_cnt[a] += int'(rise[a]);
				for (int b = a + 1; b < NUM_LINES; b++) begin
					exp_cnt[NUM_LINES + k] += int'(rise[a] & rise[b]); // same drive cycle.
					k++;
				end
			end
			for (int i = 0; i < NUM_LINES; i++)
				held[i] = (nxt[i] != cur[i]) ? 1 : held[i] + 1;
			@(posedge clki);
			#1 line_in = nxt;
			cur = nxt;
		end
		repeat (2) @(posedge clki);
		#1 line_in = '0; // falling edges are not counted.
	endtask

	// tx decoder, sampled on the falling clock edge where tx is stable.
	initial begin : tx_monitor
		int idle;
		logic [7:0] d;
		idle = 0;
		forever begin
			@(negedge clki);
			mon_valid = 1'b0;
			frame_gap = 1'b0;
			if (tx === 1'b0) begin
				repeat (HALF_BIT - 1) @(negedge clki); // middle of the start bit.
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clki);
					d[i] = tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clki);
				mon_stop = tx;
				mon_byte = d;
				mon_pos = byte_cnt % FRAME_BYTES;
				exp_byte = frame_byte(mon_pos);
				mon_valid = 1'b1;
				byte_cnt++;
				idle = 0;
			end else begin
				idle++;
				frame_gap = (idle == 10 * CLKS_PER_BIT);
			end
		end
	end

	a_quiet: assert property (@(posedge clki) disable iff (!rst_n) quiet |-> tx)
		else begin
			errors++;
			$display("ERROR %0t tx expected 1 got %b", $time, tx);
		end

	a_stop: assert property (@(posedge clki) mon_valid |-> mon_stop)
		else begin
			errors++;
			$display("ERROR %0t tx stop bit expected 1 got %b", $time, mon_stop);
		end

	a_byte: assert property (@(posedge clki) mon_valid |-> mon_byte == exp_byte)
		else begin
			errors++;
			$display("ERROR %0t tx byte %0d expected %02h got %02h",
				$time, mon_pos, exp_byte, mon_byte);
		end

	a_frame: assert property (@(posedge clki) frame_gap |-> byte_cnt % FRAME_BYTES == 0)
		else begin
			errors++;
			$display("ERROR %0t frame_pos expected 0 got %0d", $time, byte_cnt % FRAME_BYTES);
		end

	// run limit.
	always @(posedge clki) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		rx = 1'b1;          // uart idle.
		line_in = '0;
		for (int i = 0; i < FRAME_WORDS; i++)
			exp_cnt[i] = 0;
		wait (rst_n);
		quiet = 1'b1;       // no command yet, so tx must stay idle.
		repeat (1000) @(posedge clki);
		quiet = 1'b0;
		send_cmd(8'h31);
		drive_pattern();
		wait (byte_cnt >= 5);
		send_cmd(8'h32);    // lands during unload, must be ignored.
		wait (byte_cnt >= FRAME_BYTES);
		repeat (20 * CLKS_PER_BIT) @(posedge clki);
		for (int i = 0; i < FRAME_WORDS; i++)
			exp_cnt[i] = 0; // fresh frame counts only new stimulus.
		send_cmd(8'h33);
		drive_pattern();
		wait (byte_cnt >= 2 * FRAME_BYTES);
		repeat (1000) @(posedge clki); // room for a stray extra frame.
		assert (byte_cnt == 2 * FRAME_BYTES)
			else begin
				errors++;
				$display("ERROR %0t byte_cnt expected %0d got %0d",
					$time, 2 * FRAME_BYTES, byte_cnt);
			end
		$display("bytes %0d, frames %0d, errors %0d", byte_cnt, byte_cnt / FRAME_BYTES, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
src/xc_pkg.sv
src/count_if.sv
src/uart_rx.sv
src/line_sampler.sv
src/xc_accumulator.sv
src/frame_serializer.sv
src/correlator.sv
tests/tb_clock.sv
tests/tb_correlator.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_correlator
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
